// ==== logic/xdrs_bus_pkg.sv ====
`default_nettype none

package xdrs_bus_pkg;

	// --------------------
	// shared bus word formats
	// --------------------

	// one bus data word, also one stream data item
	localparam int XDRS_DATA_W = 32;
	// word address on the shared bus
	localparam int XDRS_ADDR_W = 16;

	typedef logic [XDRS_DATA_W-1:0] xdrs_data_t;
	typedef logic [XDRS_ADDR_W-1:0] xdrs_addr_t;

	// bitstream length in words
	// same width as an address so a whole memory fits
	typedef logic [XDRS_ADDR_W-1:0] xdrs_size_t;

endpackage

`default_nettype wire

// ==== logic/xdrs_rc_pkg.sv ====
`default_nettype none

package xdrs_rc_pkg;

	// --------------------
	// reconfiguration manager
	// --------------------

	// sequencer states in the order they are visited
	typedef enum logic [2:0] {
		RC_IDLE,
		RC_REQUEST,
		RC_LOAD,
		RC_RESET,
		RC_RELEASE,
		RC_DONE
	} rc_state_t;

	// region reset pulse length in clk cycles
	localparam int RC_RESET_CYCLES_DEF = 4;

endpackage

`default_nettype wire

// ==== logic/xdrs_ifs.sv ====
`timescale 1ns/100ps
`default_nettype none

// --------------------
// shared memory bus
// --------------------
// req/gnt arbitration, then sel/ack per word
interface xbus_if;
	import xdrs_bus_pkg::*;

	logic       req;
	logic       gnt;
	logic       sel;
	xdrs_addr_t addr;
	xdrs_data_t wdata;
	logic       rnw;
	logic       ack;
	xdrs_data_t rdata;

	modport master (output req, sel, addr, wdata, rnw, input gnt, ack, rdata);
	modport slave  (input req, sel, addr, wdata, rnw, output gnt, ack, rdata);
endinterface

// --------------------
// region add-on handshake
// --------------------
// all active low
interface rc_addon_if;
	logic rc_reqn;
	logic rc_ackn;
	logic rc_rstn;
	logic rc_reconfn;

	modport manager (output rc_reqn, rc_rstn, rc_reconfn, input rc_ackn);
	modport region  (input rc_reqn, rc_rstn, rc_reconfn, output rc_ackn);
endinterface

// --------------------
// bitstream load command
// --------------------
interface icap_cmd_if;
	import xdrs_bus_pkg::*;

	logic       start;
	xdrs_addr_t baddr;
	xdrs_size_t bsize;
	logic       done;

	modport initiator (output start, baddr, bsize, input done);
	modport target    (input start, baddr, bsize, output done);
endinterface

`default_nettype wire

// ==== logic/xbus_arbiter.sv ====
`timescale 1ns/100ps
`default_nettype none

module xbus_arbiter (
	input  logic   clk,
	input  logic   rst_n,
	xbus_if.slave  m0,
	xbus_if.slave  m1,
	xbus_if.master s
);

	logic [1:0] gnt_q;
	logic [1:0] gnt_nxt;
	logic       last_m1;
	logic       owner_busy;

	// current owner still holds its request
	assign owner_busy = (gnt_q[0] & m0.req) | (gnt_q[1] & m1.req);

	// round robin pick
	always_comb begin
		if (m0.req && m1.req) begin
			// both waiting so the turn goes to the one not served last
			gnt_nxt = last_m1 ? 2'b01 : 2'b10;
		end else begin
			gnt_nxt = {m1.req, m0.req};
		end
	end

	// grant is registered, so it never rises in the request cycle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			gnt_q   <= 2'b00;
			last_m1 <= 1'b1;
		end else if (!owner_busy) begin
			gnt_q <= gnt_nxt;
			if (|gnt_nxt) begin
				last_m1 <= gnt_nxt[1];
			end
		end
	end

	// --------------------
	// routing to the memory side
	// --------------------
	assign s.req   = |gnt_q;
	assign s.sel   = gnt_q[0] ? m0.sel   : (gnt_q[1] ? m1.sel   : 1'b0);
	assign s.addr  = gnt_q[0] ? m0.addr  : (gnt_q[1] ? m1.addr  : '0);
	assign s.wdata = gnt_q[0] ? m0.wdata : (gnt_q[1] ? m1.wdata : '0);
	assign s.rnw   = gnt_q[0] ? m0.rnw   : (gnt_q[1] ? m1.rnw   : 1'b1);

	// responses only reach the granted master
	assign m0.gnt   = gnt_q[0] & s.gnt;
	assign m0.ack   = gnt_q[0] & s.ack;
	assign m0.rdata = gnt_q[0] ? s.rdata : '0;
	assign m1.gnt   = gnt_q[1] & s.gnt;
	assign m1.ack   = gnt_q[1] & s.ack;
	assign m1.rdata = gnt_q[1] ? s.rdata : '0;

	a_single_grant: assert property (@(posedge clk) disable iff (!rst_n)
		!(m0.gnt && m1.gnt));

endmodule

`default_nettype wire

// ==== logic/memctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module memctrl #(
	parameter int MEM_WORDS = 1024
) (
	input  logic  clk,
	input  logic  rst_n,
	xbus_if.slave s
);
	import xdrs_bus_pkg::*;

	localparam int IDX_W = $clog2(MEM_WORDS);

	xdrs_data_t       mem [MEM_WORDS];
	xdrs_data_t       rdata_q;
	logic             ack_q;
	logic             access;
	logic [IDX_W-1:0] idx;

	// a new word starts when sel is seen with ack low
	assign access = s.sel & ~ack_q;
	// upper address bits are outside the array and wrap
	assign idx    = s.addr[IDX_W-1:0];

	// single slave, ready as soon as the arbiter owns the bus
	assign s.gnt   = s.req;
	assign s.ack   = ack_q;
	assign s.rdata = rdata_q;

	// ack one cycle after access, gone again the cycle after
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= access;
		end
	end

	always_ff @(posedge clk) begin
		if (access) begin
			if (s.rnw) begin
				rdata_q <= mem[idx];
			end else begin
				mem[idx] <= s.wdata;
			end
		end
	end

	// masters must hold sel until they see ack
	a_ack_in_sel: assert property (@(posedge clk) disable iff (!rst_n)
		s.ack |-> s.sel);

endmodule

`default_nettype wire

// ==== logic/icapi.sv ====
`timescale 1ns/100ps
`default_nettype none

module icapi (
	input  logic                      clk,
	input  logic                      rst_n,
	icap_cmd_if.target                cmd,
	xbus_if.master                    bus,
	output logic                      cfg_we,
	output xdrs_bus_pkg::xdrs_data_t  cfg_word
);
	import xdrs_bus_pkg::*;

	enum logic [2:0] {ST_IDLE, ST_REQ, ST_XFER, ST_NEXT, ST_FIN} state;

	xdrs_addr_t addr_q;
	xdrs_size_t remain_q;
	logic       req_q;
	logic       sel_q;
	logic       done_q;

	// fetch engine only ever reads
	assign bus.req   = req_q;
	assign bus.sel   = sel_q;
	assign bus.addr  = addr_q;
	assign bus.wdata = '0;
	assign bus.rnw   = 1'b1;
	assign cmd.done  = done_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state    <= ST_IDLE;
			addr_q   <= '0;
			remain_q <= '0;
			req_q    <= 1'b0;
			sel_q    <= 1'b0;
			done_q   <= 1'b0;
			cfg_we   <= 1'b0;
		end else begin
			cfg_we <= 1'b0;
			done_q <= 1'b0;
			case (state)
				ST_IDLE: if (cmd.start) begin
					addr_q   <= cmd.baddr;
					remain_q <= cmd.bsize;
					// empty bitstream skips the bus entirely
					req_q    <= (cmd.bsize != '0);
					state    <= (cmd.bsize != '0) ? ST_REQ : ST_FIN;
				end
				ST_REQ: if (bus.gnt) begin
					sel_q <= 1'b1;
					state <= ST_XFER;
				end
				ST_XFER: if (bus.ack) begin
					sel_q    <= 1'b0;
					cfg_we   <= 1'b1;
					addr_q   <= addr_q + 1'b1;
					remain_q <= remain_q - 1'b1;
					if (remain_q == xdrs_size_t'(1)) begin
						// last word hands the bus back
						req_q <= 1'b0;
						state <= ST_FIN;
					end else begin
						state <= ST_NEXT;
					end
				end
				// ack has dropped by now
				ST_NEXT: begin
					sel_q <= 1'b1;
					state <= ST_XFER;
				end
				ST_FIN: begin
					done_q <= 1'b1;
					state  <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// word capture register
	always_ff @(posedge clk) begin
		if (state == ST_XFER && bus.ack) begin
			cfg_word <= bus.rdata;
		end
	end

	a_we_granted: assert property (@(posedge clk) disable iff (!rst_n)
		cfg_we |-> bus.gnt);

endmodule

`default_nettype wire

// ==== logic/rc_manager.sv ====
`timescale 1ns/100ps
`default_nettype none

module rc_manager #(
	parameter int RC_RESET_CYCLES = xdrs_rc_pkg::RC_RESET_CYCLES_DEF
) (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     rc_start,
	input  xdrs_bus_pkg::xdrs_addr_t rc_baddr,
	input  xdrs_bus_pkg::xdrs_size_t rc_bsize,
	output logic                     rc_done,
	output logic                     rc_busy,
	icap_cmd_if.initiator            icap,
	rc_addon_if.manager              addon
);
	import xdrs_bus_pkg::*;
	import xdrs_rc_pkg::*;

	localparam int CNT_W = $clog2(RC_RESET_CYCLES + 1);

	rc_state_t        state;
	xdrs_addr_t       baddr_q;
	xdrs_size_t       bsize_q;
	logic [CNT_W-1:0] cnt;
	logic             start_q;
	logic             reqn_q;
	logic             rstn_q;
	logic             reconfn_q;

	assign icap.start       = start_q;
	assign icap.baddr       = baddr_q;
	assign icap.bsize       = bsize_q;
	assign addon.rc_reqn    = reqn_q;
	assign addon.rc_rstn    = rstn_q;
	assign addon.rc_reconfn = reconfn_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state     <= RC_IDLE;
			baddr_q   <= '0;
			bsize_q   <= '0;
			cnt       <= '0;
			start_q   <= 1'b0;
			reqn_q    <= 1'b1;
			rstn_q    <= 1'b1;
			reconfn_q <= 1'b1;
			rc_done   <= 1'b0;
			rc_busy   <= 1'b0;
		end else begin
			start_q <= 1'b0;
			case (state)
				// commands only land here so a start while busy is dropped
				// done lasts one cycle with busy already low
				RC_IDLE, RC_DONE: begin
					rc_done <= 1'b0;
					state   <= RC_IDLE;
					if (rc_start) begin
						baddr_q <= rc_baddr;
						bsize_q <= rc_bsize;
						rc_busy <= 1'b1;
						reqn_q  <= 1'b0;
						state   <= RC_REQUEST;
					end
				end
				// region drains its output before it acks
				RC_REQUEST: if (!addon.rc_ackn) begin
					reconfn_q <= 1'b0;
					start_q   <= 1'b1;
					state     <= RC_LOAD;
				end
				RC_LOAD: if (icap.done) begin
					reconfn_q <= 1'b1;
					rstn_q    <= 1'b0;
					cnt       <= CNT_W'(RC_RESET_CYCLES - 1);
					state     <= RC_RESET;
				end
				// rstn low for exactly RC_RESET_CYCLES
				RC_RESET: begin
					if (cnt == '0) begin
						rstn_q <= 1'b1;
						reqn_q <= 1'b1;
						state  <= RC_RELEASE;
					end else begin
						cnt <= cnt - 1'b1;
					end
				end
				RC_RELEASE: if (addon.rc_ackn) begin
					rc_done <= 1'b1;
					rc_busy <= 1'b0;
					state   <= RC_DONE;
				end
				default: state <= RC_IDLE;
			endcase
		end
	end

	a_reconf_in_req: assert property (@(posedge clk) disable iff (!rst_n)
		!addon.rc_reconfn |-> !addon.rc_reqn);

endmodule

`default_nettype wire

// ==== logic/rr_slot.sv ====
`timescale 1ns/100ps
`default_nettype none

module rr_slot (
	input  logic                     clk,
	input  logic                     rst_n,
	rc_addon_if.region               addon,
	input  logic                     cfg_we,
	input  xdrs_bus_pkg::xdrs_data_t cfg_word,
	input  logic                     in_valid,
	output logic                     in_ready,
	input  xdrs_bus_pkg::xdrs_data_t in_data,
	output logic                     out_valid,
	input  logic                     out_ready,
	output xdrs_bus_pkg::xdrs_data_t out_data
);
	import xdrs_bus_pkg::*;

	xdrs_data_t cfg_sum;
	xdrs_data_t data_q;
	logic       valid_q;
	logic       reconfn_q;
	logic       ackn_q;
	logic       stage_ready;
	logic       in_xfer;
	logic       out_xfer;

	// --------------------
	// isolator
	// --------------------
	// stage side is cut off while reconfn is low
	assign stage_ready = (~valid_q | out_xfer) & addon.rc_reqn;
	assign in_ready    = stage_ready & addon.rc_reconfn;
	assign out_valid   = valid_q & addon.rc_reconfn;
	assign out_data    = data_q;
	assign in_xfer     = in_valid & in_ready;
	assign out_xfer    = out_valid & out_ready;
	assign addon.rc_ackn = ackn_q;

	// configuration store, reloaded from zero on each new load
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cfg_sum   <= '0;
			reconfn_q <= 1'b1;
		end else begin
			reconfn_q <= addon.rc_reconfn;
			if (!addon.rc_reconfn && reconfn_q) begin
				cfg_sum <= '0;
			end else if (cfg_we) begin
				cfg_sum <= cfg_sum + cfg_word;
			end
		end
	end

	// one item output register
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_q <= 1'b0;
		end else if (!addon.rc_rstn) begin
			valid_q <= 1'b0;
		end else if (in_xfer) begin
			valid_q <= 1'b1;
		end else if (out_xfer) begin
			valid_q <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (in_xfer) begin
			data_q <= in_data + cfg_sum;
		end
	end

	// ack once empty, release after reqn rises
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ackn_q <= 1'b1;
		end else if (!addon.rc_reqn) begin
			if (!valid_q) begin
				ackn_q <= 1'b0;
			end
		end else begin
			ackn_q <= 1'b1;
		end
	end

	a_out_hold: assert property (@(posedge clk) disable iff (!rst_n)
		(out_valid && !out_ready) |=> $stable(out_data));

endmodule

`default_nettype wire

// ==== logic/xdrs_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module xdrs_top #(
	parameter int MEM_WORDS       = 1024,
	parameter int RC_RESET_CYCLES = xdrs_rc_pkg::RC_RESET_CYCLES_DEF
) (
	input  logic                     clk,
	input  logic                     rst_n,
	// host bus master
	input  logic                     host_req,
	output logic                     host_gnt,
	input  logic                     host_sel,
	input  xdrs_bus_pkg::xdrs_addr_t host_addr,
	input  xdrs_bus_pkg::xdrs_data_t host_wdata,
	input  logic                     host_rnw,
	output logic                     host_ack,
	output xdrs_bus_pkg::xdrs_data_t host_rdata,
	// reconfiguration command
	input  logic                     rc_start,
	input  xdrs_bus_pkg::xdrs_addr_t rc_baddr,
	input  xdrs_bus_pkg::xdrs_size_t rc_bsize,
	output logic                     rc_done,
	output logic                     rc_busy,
	// stream through the region
	input  logic                     in_valid,
	output logic                     in_ready,
	input  xdrs_bus_pkg::xdrs_data_t in_data,
	output logic                     out_valid,
	input  logic                     out_ready,
	output xdrs_bus_pkg::xdrs_data_t out_data
);
	import xdrs_bus_pkg::*;

	logic       cfg_we;
	xdrs_data_t cfg_word;

	xbus_if     host_bus ();
	xbus_if     icap_bus ();
	xbus_if     mem_bus  ();
	icap_cmd_if icap_cmd ();
	rc_addon_if addon    ();

	// --------------------
	// host port on master 0
	// --------------------
	assign host_bus.req   = host_req;
	assign host_bus.sel   = host_sel;
	assign host_bus.addr  = host_addr;
	assign host_bus.wdata = host_wdata;
	assign host_bus.rnw   = host_rnw;
	assign host_gnt       = host_bus.gnt;
	assign host_ack       = host_bus.ack;
	assign host_rdata     = host_bus.rdata;

	// --------------------
	// shared datapath
	// --------------------
	xbus_arbiter u_xbus_arbiter (.clk, .rst_n, .m0(host_bus), .m1(icap_bus), .s(mem_bus));

	memctrl #(.MEM_WORDS(MEM_WORDS)) u_memctrl (.clk, .rst_n, .s(mem_bus));

	// --------------------
	// reconfiguration layer
	// --------------------
	rc_manager #(.RC_RESET_CYCLES(RC_RESET_CYCLES)) u_rc_manager (
		.clk, .rst_n, .rc_start, .rc_baddr, .rc_bsize, .rc_done, .rc_busy,
		.icap(icap_cmd), .addon(addon)
	);

	icapi u_icapi (.clk, .rst_n, .cmd(icap_cmd), .bus(icap_bus), .cfg_we, .cfg_word);

	// region slot with its isolator
	rr_slot u_rr_slot (
		.clk, .rst_n, .addon(addon), .cfg_we, .cfg_word,
		.in_valid, .in_ready, .in_data, .out_valid, .out_ready, .out_data
	);

endmodule

`default_nettype wire

// ==== testbench/tb_xdrs.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_xdrs;
	import xdrs_bus_pkg::*;

	localparam int RST_CYCLES = 4;
	localparam int WAIT_LIMIT = 2000;
	localparam int BS_WORDS   = 16;
	// memory areas for plain words and for the two bitstreams
	localparam int ADDR_M     = 'h010;
	localparam int ADDR_A     = 'h100;
	localparam int ADDR_B     = 'h200;

	logic       clk = 1'b0;
	logic       rst_n;
	logic       host_req;
	logic       host_gnt;
	logic       host_sel;
	xdrs_addr_t host_addr;
	xdrs_data_t host_wdata;
	logic       host_rnw;
	logic       host_ack;
	xdrs_data_t host_rdata;
	logic       rc_start;
	xdrs_addr_t rc_baddr;
	xdrs_size_t rc_bsize;
	logic       rc_done;
	logic       rc_busy;
	logic       in_valid;
	logic       in_ready;
	xdrs_data_t in_data;
	logic       out_valid;
	logic       out_ready;
	xdrs_data_t out_data;

	// scoreboard state
	logic [15:0] lfsr_q;
	xdrs_data_t  cfg_words[$];
	xdrs_data_t  new_words[$];
	xdrs_data_t  exp_q[$];
	xdrs_data_t  mem_model[int];
	xdrs_data_t  exp_val;
	int          errors;
	int          err_mark;
	int          checks;
	int          tests_run;
	int          tests_failed;
	logic        reconfig_over;

	xdrs_top #(.MEM_WORDS(1024), .RC_RESET_CYCLES(RST_CYCLES)) u_xdrs_top (.*);

	// 8 ns clock
	always #4 clk = ~clk;

	// --------------------
	// reference model
	// --------------------
	// 16 bit fibonacci lfsr with taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	// one lfsr step per bit taken
	task automatic rand_bits(input int n, output xdrs_data_t v);
		int i;
		v = '0;
		for (i = 0; i < n; i++) begin
			lfsr_q = lfsr_next(lfsr_q);
			v = {v[30:0], lfsr_q[0]};
		end
	endtask

	// region output is the input plus the sum of the loaded words modulo 2**32
	function automatic xdrs_data_t ref_out(input xdrs_data_t din);
		xdrs_data_t s;
		s = din;
		foreach (cfg_words[i]) begin
			s = s + cfg_words[i];
		end
		return s;
	endfunction

	// compare on output transfers and queue on input transfers
	// sampled at negedge since the transfer itself lands on the next posedge
	always @(negedge clk) begin
		if (rst_n) begin
			if (out_valid && out_ready) begin
				if (exp_q.size() == 0) begin
					errors++;
					$display("** Error at %0t: unexpected output item %h", $time, out_data);
				end else begin
					exp_val = exp_q.pop_front();
					checks++;
					if (out_data !== exp_val) begin
						errors++;
						$display("** Error at %0t: out_data %h, expected %h",
							$time, out_data, exp_val);
					end
				end
			end
			if (in_valid && in_ready) begin
				exp_q.push_back(ref_out(in_data));
			end
		end
	end

	task automatic abort_timeout(input string what);
		$display("timeout while waiting for %s at %0t", what, $time);
		$display("Test failures found");
		$finish;
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (errors == err_mark) begin
			$display("test %0d %s: ok", tests_run, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: %0d errors", tests_run, name, errors - err_mark);
		end
		err_mark = errors;
	endtask

	// --------------------
	// host bus master
	// --------------------
	task automatic host_access(input int addr, input xdrs_data_t wd, input logic rnw,
		output xdrs_data_t rd);
		int guard;
		@(posedge clk);
		host_req <= 1'b1;
		guard = 0;
		do begin
			@(negedge clk);
			guard++;
		end while (!host_gnt && guard < WAIT_LIMIT);
		if (!host_gnt) abort_timeout("host grant");
		@(posedge clk);
		host_sel   <= 1'b1;
		host_addr  <= xdrs_addr_t'(addr);
		host_wdata <= wd;
		host_rnw   <= rnw;
		guard = 0;
		do begin
			@(negedge clk);
			guard++;
		end while (!host_ack && guard < WAIT_LIMIT);
		if (!host_ack) abort_timeout("host ack");
		// memory answers one cycle after it sees sel
		if (guard != 2) begin
			errors++;
			$display("** Error at %0t: host ack came %0d cycles after sel, expected 1",
				$time, guard - 1);
		end
		// rdata is valid in the ack cycle
		rd = host_rdata;
		@(posedge clk);
		host_sel <= 1'b0;
		guard = 0;
		do begin
			@(negedge clk);
			guard++;
		end while (host_ack && guard < WAIT_LIMIT);
		if (host_ack) abort_timeout("host ack release");
		@(posedge clk);
		host_req <= 1'b0;
		guard = 0;
		do begin
			@(negedge clk);
			guard++;
		end while (host_gnt && guard < WAIT_LIMIT);
		if (host_gnt) abort_timeout("host grant release");
	endtask

	task automatic host_write(input int addr, input xdrs_data_t wd);
		xdrs_data_t unused;
		host_access(addr, wd, 1'b0, unused);
		mem_model[addr] = wd;
	endtask

	task automatic check_read(input int addr);
		xdrs_data_t rd;
		host_access(addr, '0, 1'b1, rd);
		if (rd !== mem_model[addr]) begin
			errors++;
			$display("** Error at %0t: read 0x%h gave %h, expected %h",
				$time, addr, rd, mem_model[addr]);
		end
	endtask

	// fresh lfsr words go into memory and stay aside until the load is done
	task automatic write_bitstream(input int addr);
		xdrs_data_t d;
		int i;
		new_words.delete();
		for (i = 0; i < BS_WORDS; i++) begin
			rand_bits(32, d);
			host_write(addr + i, d);
			new_words.push_back(d);
		end
	endtask

	// --------------------
	// reconfiguration and stream
	// --------------------
	task automatic pulse_start(input int addr);
		@(posedge clk);
		rc_start <= 1'b1;
		rc_baddr <= xdrs_addr_t'(addr);
		rc_bsize <= xdrs_size_t'(BS_WORDS);
		@(posedge clk);
		rc_start <= 1'b0;
	endtask

	task automatic wait_rc_done;
		int guard;
		guard = 0;
		do begin
			@(negedge clk);
			guard++;
		end while (!rc_done && guard < WAIT_LIMIT);
		if (!rc_done) abort_timeout("rc_done");
		cfg_words = new_words;
	endtask

	task automatic drain_stream;
		int guard;
		@(posedge clk);
		out_ready <= 1'b1;
		guard = 0;
		do begin
			@(negedge clk);
			guard++;
		end while ((exp_q.size() != 0 || out_valid) && guard < WAIT_LIMIT);
		if (exp_q.size() != 0) abort_timeout("stream drain");
	endtask

	// valid is held until accepted and jitter randomizes valid and ready
	task automatic stream_items(input int n, input bit jitter);
		int sent;
		int guard;
		int c0;
		bit pending;
		xdrs_data_t d;
		xdrs_data_t b;
		sent = 0;
		guard = 0;
		pending = 0;
		c0 = checks;
		while (sent < n) begin
			@(posedge clk);
			if (!pending) begin
				b = 1;
				if (jitter) rand_bits(1, b);
				if (b[0]) begin
					rand_bits(32, d);
					in_valid <= 1'b1;
					in_data  <= d;
					pending = 1;
				end else begin
					in_valid <= 1'b0;
				end
			end
			b = 1;
			if (jitter) rand_bits(1, b);
			out_ready <= b[0];
			@(negedge clk);
			if (in_valid && in_ready) begin
				sent++;
				pending = 0;
			end
			guard++;
			if (guard > WAIT_LIMIT) abort_timeout("stream input");
		end
		@(posedge clk);
		in_valid <= 1'b0;
		drain_stream();
		if (checks - c0 != n) begin
			errors++;
			$display("** Error at %0t: %0d items sent, %0d came out", $time, n, checks - c0);
		end
	endtask

	// busy must hold until done and late starts must not start a second run
	task automatic check_busy_hold;
		int guard;
		int low_cycles;
		int extra_done;
		pulse_start(ADDR_B);
		@(negedge clk);
		if (!rc_busy) begin
			errors++;
			$display("** Error at %0t: rc_busy did not rise after rc_start", $time);
		end
		guard = 0;
		low_cycles = 0;
		while (!rc_done) begin
			guard++;
			if (guard > WAIT_LIMIT) abort_timeout("rc_done while busy");
			@(posedge clk);
			rc_start <= (guard == 3 || guard == 9);
			@(negedge clk);
			if (!u_xdrs_top.addon.rc_rstn) low_cycles++;
			if (!rc_busy && !rc_done) begin
				errors++;
				$display("** Error at %0t: rc_busy fell before rc_done", $time);
			end
		end
		if (low_cycles != RST_CYCLES) begin
			errors++;
			$display("** Error at %0t: region reset low %0d cycles, expected %0d",
				$time, low_cycles, RST_CYCLES);
		end
		// observation window for a stray second run
		extra_done = 0;
		repeat (150) begin
			@(negedge clk);
			if (rc_done) extra_done++;
		end
		if (extra_done != 0) begin
			errors++;
			$display("** Error at %0t: rc_start while busy caused %0d more rc_done pulses",
				$time, extra_done);
		end
	endtask

	// --------------------
	// test sequence
	// --------------------
	initial begin
		rst_n      = 1'b0;
		host_req   = 1'b0;
		host_sel   = 1'b0;
		host_addr  = '0;
		host_wdata = '0;
		host_rnw   = 1'b1;
		rc_start   = 1'b0;
		rc_baddr   = '0;
		rc_bsize   = '0;
		in_valid   = 1'b0;
		in_data    = '0;
		out_ready  = 1'b0;
		lfsr_q     = 16'd7;
		errors     = 0;
		err_mark   = 0;
		checks     = 0;
		tests_run  = 0;
		tests_failed  = 0;
		reconfig_over = 1'b0;
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;

		// plain words through the host port
		begin : t_mem
			xdrs_data_t d;
			int i;
			for (i = 0; i < 8; i++) begin
				rand_bits(32, d);
				host_write(ADDR_M + i, d);
			end
			for (i = 0; i < 8; i++) begin
				check_read(ADDR_M + i);
			end
		end
		finish_test("memory access");

		// config sum still zero
		stream_items(20, 0);
		finish_test("passthrough");

		write_bitstream(ADDR_A);
		pulse_start(ADDR_A);
		wait_rc_done();
		stream_items(20, 0);
		finish_test("reconfiguration");

		stream_items(60, 1);
		finish_test("back-pressure");

		// host reads compete with the bitstream fetch
		write_bitstream(ADDR_B);
		reconfig_over = 1'b0;
		fork
			begin
				pulse_start(ADDR_B);
				wait_rc_done();
				reconfig_over = 1'b1;
			end
			begin : host_reads
				int k;
				k = 0;
				while (!reconfig_over) begin
					check_read(ADDR_M + (k % 8));
					k++;
				end
			end
		join
		stream_items(20, 0);
		finish_test("contention and replacement");

		check_busy_hold();
		stream_items(8, 0);
		finish_test("busy hold and reset pulse");

		$display("tests %0d, failed %0d, item checks %0d, errors %0d",
			tests_run, tests_failed, checks, errors);
		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== filelist.f ====
logic/xdrs_bus_pkg.sv
logic/xdrs_rc_pkg.sv
logic/xdrs_ifs.sv
logic/xbus_arbiter.sv
logic/memctrl.sv
logic/icapi.sv
logic/rc_manager.sv
logic/rr_slot.sv
logic/xdrs_top.sv
testbench/tb_xdrs.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_xdrs
RTL_TOP    := xdrs_top
FILELIST   := filelist.f
FLAGS      := --binary --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only -Wall --timing
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q 'All tests passed!' $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
